//--- common/video_pkg.sv
/* Video package: 720p frame geometry, RGB565 pixel type and the
   eight-band colour-bar palette used by the read-out pattern */
`default_nettype none

package video_pkg;

	// ==================================================
	// Frame geometry
	// ==================================================
	localparam int H_PIXELS  = 1280;          // Pixels per line
	localparam int V_LINES   = 720;           // Lines per frame
	localparam int COL_W     = $clog2(H_PIXELS); // Pixel column index width

	// ==================================================
	// Colour bars
	// ==================================================
	localparam int NUM_BARS  = 8;
	localparam int BAR_WIDTH = H_PIXELS / NUM_BARS; // 160 pixels per band
	localparam int BAR_IDX_W = $clog2(NUM_BARS);

	// One 16 bit pixel, packed as 5/6/5
	typedef logic [15:0] pixel_t;

	// Band colours from left to right
	// Values are BGR565, so blue sits in the top five bits
	localparam pixel_t BAR_COLORS [0:NUM_BARS-1] = '{
		16'h001F,  // Red
		16'h07E0,  // Green
		16'hF800,  // Blue
		16'h07FF,  // Yellow
		16'hFFE0,  // Cyan
		16'hF81F,  // Magenta
		16'hFFFF,  // White
		16'h0000   // Black
	};

endpackage

`default_nettype wire

//--- common/dma_pkg.sv
/* DMA read package: read word type, frame position struct and
   session constants for the frame read-out path */
`default_nettype none

package dma_pkg;

	// ==================================================
	// Read word
	// ==================================================
	localparam int RD_WORD_W    = 128;
	localparam int PIX_PER_WORD = RD_WORD_W / $bits(video_pkg::pixel_t); // 8

	typedef logic [RD_WORD_W-1:0] rd_word_t;

	// ==================================================
	// Frame walk
	// ==================================================
	localparam int WORDS_PER_LINE = video_pkg::H_PIXELS / PIX_PER_WORD; // 160
	localparam int FRAME_WORDS    = WORDS_PER_LINE * video_pkg::V_LINES; // 115200
	localparam int WORD_X_W       = 8;
	localparam int LINE_Y_W       = 10;

	localparam logic [WORD_X_W-1:0] LAST_WORD_X = WORD_X_W'(WORDS_PER_LINE - 1);
	localparam logic [LINE_Y_W-1:0] LAST_LINE_Y = LINE_Y_W'(FRAME_WORDS / WORDS_PER_LINE - 1);

	// Position of the next word to be read
	typedef struct packed {
		logic [WORD_X_W-1:0] word_x;  // 0..159
		logic [LINE_Y_W-1:0] line_y;  // 0..719
	} frame_pos_t;

	// Read frame sync stretch
	localparam int FSYNC_STRETCH = 31;
	localparam int FSYNC_CNT_W   = 6;

endpackage

`default_nettype wire

//--- rtl/frame_dma/frame_read_session.sv
/* Frame read session tracker: opens a session on a DMA start command,
   stretches the read frame sync and walks the word position */
`timescale 1ns/1ns
`default_nettype none

module frame_read_session (
	input  wire                  pclk_div2,
	input  wire                  core_rst_n,
	input  wire                  i_cmd_start,      // DMA transmit restart
	input  wire                  i_rd_en,          // Read request from DMA
	output logic                 o_session_start,  // Accepted start, one cycle
	output dma_pkg::frame_pos_t  o_pos,            // Next word to be read
	output logic                 o_session_active,
	output logic                 o_rd_fsync
);

	logic [dma_pkg::FSYNC_CNT_W-1:0] fsync_cnt;   // Remaining stretch cycles
	logic                            at_last_word; // Position (159, 719)

	// A start is only taken while idle
	assign o_session_start = i_cmd_start & ~o_session_active;

	assign at_last_word = (o_pos.word_x == dma_pkg::LAST_WORD_X) &&
		(o_pos.line_y == dma_pkg::LAST_LINE_Y);

	// ==================================================
	// Session flag
	// ==================================================
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			o_session_active <= 1'b0;
		end else if (o_session_start) begin
			o_session_active <= 1'b1;
		end else if (o_session_active && i_rd_en && at_last_word) begin
			o_session_active <= 1'b0;  // Whole frame consumed
		end
	end

	// ==================================================
	// Frame sync stretch
	// ==================================================
	// High from the cycle after start for FSYNC_STRETCH cycles
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			fsync_cnt  <= '0;
			o_rd_fsync <= 1'b0;
		end else if (o_session_start) begin
			fsync_cnt  <= dma_pkg::FSYNC_CNT_W'(dma_pkg::FSYNC_STRETCH - 1);
			o_rd_fsync <= 1'b1;
		end else if (fsync_cnt != '0) begin
			fsync_cnt <= fsync_cnt - dma_pkg::FSYNC_CNT_W'(1);
		end else begin
			o_rd_fsync <= 1'b0;  // Stretch done
		end
	end

	// ==================================================
	// Word position
	// ==================================================
	// Advances on every read, in or out of a session
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			o_pos <= '0;
		end else if (o_session_start) begin
			o_pos <= '0;  // Read on start cycle is dropped
		end else if (i_rd_en) begin
			if (o_pos.word_x == dma_pkg::LAST_WORD_X) begin
				o_pos.word_x <= '0;
				if (o_pos.line_y == dma_pkg::LAST_LINE_Y)
					o_pos.line_y <= '0;  // Frame wrap
				else
					o_pos.line_y <= o_pos.line_y + dma_pkg::LINE_Y_W'(1);
			end else begin
				o_pos.word_x <= o_pos.word_x + dma_pkg::WORD_X_W'(1);
			end
		end
	end

	// A session closes only with the frame wrap back to the origin
	a_end_at_frame_wrap: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		$fell(o_session_active) |-> (o_pos == '0));

	a_pos_in_range: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		(o_pos.word_x <= dma_pkg::LAST_WORD_X) && (o_pos.line_y <= dma_pkg::LAST_LINE_Y));

endmodule

`default_nettype wire

//--- rtl/frame_dma/bar_word_source.sv
/* Colour-bar word source: picks the band colour for the current word
   position and returns it as eight pixels one cycle after a read */
`timescale 1ns/1ns
`default_nettype none

module bar_word_source (
	input  wire                  pclk_div2,
	input  wire                  core_rst_n,
	input  wire                  i_rd_en,          // Read request from DMA
	input  wire                  i_session_start,  // Start cycle, read is dropped
	input  wire dma_pkg::frame_pos_t i_pos,        // Word being read
	output dma_pkg::rd_word_t    o_rd_data
);

	logic [video_pkg::COL_W-1:0]     pix_col;   // First pixel column of word
	logic [video_pkg::BAR_IDX_W-1:0] bar_idx;
	video_pkg::pixel_t               bar_pix;
	logic                            rd_accept;

	// ==================================================
	// Colour lookup
	// ==================================================
	assign pix_col = video_pkg::COL_W'(i_pos.word_x * dma_pkg::PIX_PER_WORD);

	// All eight pixels of a word share one band, 160 is a multiple of 8
	assign bar_idx = video_pkg::BAR_IDX_W'(pix_col / video_pkg::BAR_WIDTH);
	assign bar_pix = video_pkg::BAR_COLORS[bar_idx];

	assign rd_accept = i_rd_en & ~i_session_start;

	// ==================================================
	// Read data register
	// ==================================================
	// One cycle read latency, value held between reads
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			o_rd_data <= '0;
		end else if (rd_accept) begin
			o_rd_data <= {dma_pkg::PIX_PER_WORD{bar_pix}};
		end
	end

	a_data_known: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		!$isunknown(o_rd_data));

endmodule

`default_nettype wire

//--- rtl/frame_read_top.sv
/* Frame read-out top: session tracker feeding the colour-bar word
   source that answers DMA read requests */
`timescale 1ns/1ns
`default_nettype none

module frame_read_top (
	input  wire                    pclk_div2,
	input  wire                    core_rst_n,
	input  wire                    i_cmd_start,   // DMA transmit restart
	input  wire                    i_rd_en,       // DMA read request
	output wire dma_pkg::rd_word_t o_rd_data,     // Valid one cycle after read
	output wire                    o_rd_fsync,
	output wire                    o_session_active
);

	// ==================================================
	// Internal wiring
	// ==================================================
	wire dma_pkg::frame_pos_t rd_pos;         // Next word position
	wire                      session_start;  // Accepted start cycle

	// Session control and position walk
	frame_read_session u_session (
		.pclk_div2        (pclk_div2),
		.core_rst_n       (core_rst_n),
		.i_cmd_start      (i_cmd_start),
		.i_rd_en          (i_rd_en),
		.o_session_start  (session_start),
		.o_pos            (rd_pos),
		.o_session_active (o_session_active),
		.o_rd_fsync       (o_rd_fsync)
	);

	// Pattern word per read
	bar_word_source u_word_src (
		.pclk_div2        (pclk_div2),
		.core_rst_n       (core_rst_n),
		.i_rd_en          (i_rd_en),
		.i_session_start  (session_start),
		.i_pos            (rd_pos),
		.o_rd_data        (o_rd_data)
	);

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
/* Testbench clock and reset: 8 ns pclk_div2, reset held for 16 cycles */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	localparam int HALF_PERIOD_NS = 4;
	localparam int RST_CYCLES     = 16;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1;  // Released together with the stimulus
	end

endmodule

`default_nettype wire

//--- dv/tb_frame_read.sv
/* Frame read-out testbench: random reads and starts from an LFSR,
   checked cycle by cycle against a session and colour-bar model */
`timescale 1ns/1ns
`default_nettype none

module tb_frame_read;

	// Two frames at a 3/4 read rate take about 307k cycles
	localparam int MAX_CYCLES   = 400_000;
	localparam int SESSIONS_RUN = 2;
	localparam int TAIL_CYCLES  = 200;   // Idle reads after the last frame

	logic              pclk_div2;
	logic              core_rst_n;
	logic              i_cmd_start;
	logic              i_rd_en;
	dma_pkg::rd_word_t o_rd_data;
	logic              o_rd_fsync;
	logic              o_session_active;

	logic [15:0]       lfsr_state;

	// Model state, as the DUT outputs should look after each edge
	logic              m_active;
	int                m_fsync_left;
	int                m_x;
	int                m_reads;          // Reads taken in the open session
	dma_pkg::rd_word_t m_data;

	int                sessions_done;
	int                ignored_starts;   // Starts seen while a session was open
	int                cycle_cnt = 0;

	tb_clk_gen u_clk_gen (
		.o_clk   (pclk_div2),
		.o_rst_n (core_rst_n)
	);

	frame_read_top dut0 (
		.pclk_div2        (pclk_div2),
		.core_rst_n       (core_rst_n),
		.i_cmd_start      (i_cmd_start),
		.i_rd_en          (i_rd_en),
		.o_rd_data        (o_rd_data),
		.o_rd_fsync       (o_rd_fsync),
		.o_session_active (o_session_active)
	);

	// ==================================================
	// Random source
	// ==================================================
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[14:0], lfsr_state[0]};  // One step per bit
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================
	// Eight copies of the band colour under the word's first column
	function automatic dma_pkg::rd_word_t bar_word(input int x);
		int                              col;
		logic [video_pkg::BAR_IDX_W-1:0] band;
		dma_pkg::rd_word_t               w;
		col  = x * dma_pkg::PIX_PER_WORD;
		band = video_pkg::BAR_IDX_W'(col / video_pkg::BAR_WIDTH);
		w    = '0;
		for (int p = 0; p < dma_pkg::PIX_PER_WORD; p++)
			w = {w[111:0], video_pkg::BAR_COLORS[band]};
		return w;
	endfunction

	task automatic model_step(input logic start_in, input logic rd_in);
		if (start_in && !m_active) begin
			m_active     = 1'b1;  // Read in this cycle is dropped
			m_reads      = 0;
			m_fsync_left = dma_pkg::FSYNC_STRETCH;
			m_x          = 0;
		end else begin
			if (m_fsync_left > 0)
				m_fsync_left--;
			if (start_in)
				ignored_starts++;
			if (rd_in) begin
				m_data = bar_word(m_x);
				if (m_active) begin
					m_reads++;
					if (m_reads == dma_pkg::FRAME_WORDS) begin
						m_active = 1'b0;  // Full frame consumed
						sessions_done++;
					end
				end
				m_x++;
				if (m_x == dma_pkg::WORDS_PER_LINE)
					m_x = 0;
			end
		end
	endtask

	// ==================================================
	// Checks
	// ==================================================
	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h",
				$time, what, got, exp);
			$display("Done: errors found");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic check_outputs();
		logic exp_fsync;
		exp_fsync = (m_fsync_left > 0);
		check_value("o_session_active", 128'(o_session_active), 128'(m_active));
		check_value("o_rd_fsync", 128'(o_rd_fsync), 128'(exp_fsync));
		check_value("o_rd_data", o_rd_data, m_data);
	endtask

	always @(posedge pclk_div2) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			$display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$fatal(1, "Timeout");
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		logic [15:0] bits;
		logic        cur_start;
		logic        cur_rd;
		int          tail;
		lfsr_state     = 16'd72;
		i_cmd_start    = 1'b0;
		i_rd_en        = 1'b0;
		cur_start      = 1'b0;
		cur_rd         = 1'b0;
		m_active       = 1'b0;
		m_fsync_left   = 0;
		m_x            = 0;
		m_reads        = 0;
		m_data         = '0;
		sessions_done  = 0;
		ignored_starts = 0;
		tail           = 0;

		@(posedge core_rst_n);
		check_outputs();  // Reset values

		while (tail < TAIL_CYCLES) begin
			@(posedge pclk_div2);
			#1;
			model_step(cur_start, cur_rd);
			check_outputs();
			take_bits(2, bits);
			cur_rd = (bits[1:0] != 2'b00);       // About 3/4 busy
			take_bits(6, bits);
			cur_start = (bits[5:0] == 6'h3F);    // Rare start pulses
			i_rd_en     = cur_rd;
			i_cmd_start = cur_start;
			if (sessions_done >= SESSIONS_RUN)
				tail++;
		end

		if (ignored_starts > 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("No start arrived during an open session, stimulus incomplete");
			$display("Done: errors found");
			$fatal(1, "Stimulus incomplete");
		end
	end

endmodule

`default_nettype wire

//--- all.f
common/video_pkg.sv
common/dma_pkg.sv
rtl/frame_dma/frame_read_session.sv
rtl/frame_dma/bar_word_source.sv
rtl/frame_read_top.sv
dv/tb_clk_gen.sv
dv/tb_frame_read.sv

//--- run.sh
#!/bin/sh
# Build the frame read-out testbench with Verilator and run it

cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module tb_frame_read -o sim_frame_read &&
./obj_dir/sim_frame_read | tee /dev/stderr | grep -qx "Done: no errors" &&
echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }
